/* Bender.yml */
package:
  name: if_stage

sources:
  - if_pkg.sv
  - if_pc_mux.sv
  - if_prefetch_ctrl.sv
  - if_fetch_fifo.sv
  - if_dummy_issue.sv
  - if_id_register.sv
  - if_stage_top.sv
  - target: test
    files:
      - tb_instr_mem.sv
      - tb_if_stage.sv

/* if_dummy_issue.sv */
// Outputs are combinational, only the LFSR and gap counter are registered
// A dummy takes the head entry's address even when the buffer is empty
// Gap limit follows dummy_freq live, the LFSR only moves on a dummy
`timescale 1ns/10ps
`default_nettype none

module if_dummy_issue import if_pkg::*; (
  input  logic          clk,
  input  logic          rst_n,
  input  ctrl_if_t      ctrl_i,
  input  xsecure_ctrl_t xsecure_i,
  input  logic          head_valid_i,
  input  fetch_entry_t  head_i,
  input  logic          id_ready_i,
  output logic          pop_o,
  output logic          if_valid_o,
  output logic          issue_o,
  output fetch_entry_t  issue_entry_o,
  output logic          issue_dummy_o,
  output logic          lfsr_shift_o
);

  lfsr_t       lfsr_q;
  gap_cnt_t    gap_cnt_q;
  gap_cnt_t    gap_lim;
  logic        first_q;
  logic [6:0]  gap_range;
  logic        dummy_due;
  logic        real_issue;
  instr_word_t dummy_word;

  //////////////////////////////
  // Dummy pacing
  //////////////////////////////

  // Range of 4 * (freq + 1), from 4 up to 64
  assign gap_range = {1'b0, xsecure_i.dummy_freq, 2'b00} + 7'd4;
  assign gap_lim   = gap_cnt_t'({1'b0, lfsr_q[5:0]} % gap_range);

  // At least one real instruction, then gap_lim more
  assign dummy_due = xsecure_i.dummy_en && first_q && (gap_cnt_q >= gap_lim);

  // Random ALU op into x0
  assign dummy_word = {7'b0, lfsr_q[7:3], lfsr_q[4:0], lfsr_q[2:0], 5'b0, DUMMY_OPCODE};

  //////////////////////////////
  // Handshake
  //////////////////////////////

  assign if_valid_o = (head_valid_i || dummy_due) && !ctrl_i.kill_if && !ctrl_i.halt_if;
  // Kill drains the head, a dummy leaves it in place
  assign pop_o      = head_valid_i &&
                      (ctrl_i.kill_if || (id_ready_i && !dummy_due && !ctrl_i.halt_if));
  assign issue_o    = if_valid_o && id_ready_i;
  assign real_issue = issue_o && !dummy_due;

  assign issue_dummy_o = dummy_due;
  assign lfsr_shift_o  = issue_o && dummy_due;

  assign issue_entry_o = '{addr: head_i.addr,
                           word: dummy_due ? dummy_word : head_i.word,
                           bus_err: dummy_due ? 1'b0 : head_i.bus_err};

  // LFSR and count of real instructions since the last dummy
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lfsr_q    <= LFSR_SEED;
      gap_cnt_q <= '0;
      first_q   <= 1'b0;
    end else if (lfsr_shift_o) begin
      lfsr_q    <= {lfsr_q[6:0], ^(lfsr_q & LFSR_TAPS)};
      gap_cnt_q <= '0;
      first_q   <= 1'b0;
    end else if (real_issue) begin
      if (!first_q) begin
        first_q <= 1'b1;
      end else if (gap_cnt_q < gap_lim) begin
        // Saturates so a disabled dummy fires at once when enabled
        gap_cnt_q <= gap_cnt_q + 6'd1;
      end
    end
  end

endmodule

`default_nettype wire

/* if_fetch_fifo.sv */
// Push when full and pop when empty are ignored
// Flush has priority over push and pop in the same cycle
`timescale 1ns/10ps
`default_nettype none

module if_fetch_fifo import if_pkg::*; (
  input  logic         clk,
  input  logic         rst_n,
  input  logic         flush_i,
  input  logic         push_i,
  input  fetch_entry_t push_entry_i,
  input  logic         pop_i,
  output logic         head_valid_o,
  output fetch_entry_t head_o,
  output logic [1:0]   free_o
);

  fetch_entry_t           mem_q [FETCH_DEPTH];
  logic [FETCH_PTR_W-1:0] wr_ptr_q;
  logic [FETCH_PTR_W-1:0] rd_ptr_q;
  logic [1:0]             count_q;
  logic                   push_ok;
  logic                   pop_ok;

  assign push_ok = push_i && (count_q != 2'(FETCH_DEPTH));
  assign pop_ok  = pop_i && head_valid_o;

  // Head is presented as soon as it is written
  assign head_valid_o = (count_q != 2'd0);
  assign head_o       = mem_q[rd_ptr_q];
  assign free_o       = 2'(FETCH_DEPTH) - count_q;

  // Pointers and fill level
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= 2'd0;
    end else if (flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= 2'd0;
    end else begin
      if (push_ok) begin
        wr_ptr_q <= wr_ptr_q + FETCH_PTR_W'(1);
      end
      if (pop_ok) begin
        rd_ptr_q <= rd_ptr_q + FETCH_PTR_W'(1);
      end
      count_q <= count_q + {1'b0, push_ok} - {1'b0, pop_ok};
    end
  end

  // Entry storage
  always_ff @(posedge clk) begin
    if (push_ok) begin
      mem_q[wr_ptr_q] <= push_entry_i;
    end
  end

endmodule

`default_nettype wire

/* if_id_register.sv */
// Loads on issue, clears valid when ID takes nothing new
// Holds everything while ID stalls
`timescale 1ns/10ps
`default_nettype none

module if_id_register import if_pkg::*; (
  input  logic         clk,
  input  logic         rst_n,
  input  logic         issue_i,
  input  fetch_entry_t issue_entry_i,
  input  logic         issue_dummy_i,
  input  logic         id_ready_i,
  output if_id_pipe_t  if_id_pipe_o
);

  // IF/ID pipeline register
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      if_id_pipe_o <= '0;
    end else if (issue_i) begin
      if_id_pipe_o.instr_valid <= 1'b1;
      if_id_pipe_o.pc          <= issue_entry_i.addr;
      if_id_pipe_o.instr       <= issue_entry_i.word;
      // Dummies never carry a fetch error
      if_id_pipe_o.bus_err     <= issue_entry_i.bus_err;
      if_id_pipe_o.dummy       <= issue_dummy_i;
    end else if (id_ready_i) begin
      // ID consumed the old one and nothing replaced it
      if_id_pipe_o.instr_valid <= 1'b0;
    end
  end

endmodule

`default_nettype wire

/* if_pc_mux.sv */
// Purely combinational, the target is valid only while pc_set is high
// Bits 1:0 of every target are cleared, fetch is word aligned
`timescale 1ns/10ps
`default_nettype none

module if_pc_mux import if_pkg::*; (
  input  ctrl_if_t    ctrl_i,
  input  pc_targets_t targets_i,
  output addr_t       redirect_addr_o,
  output logic        csr_mtvec_init_o
);

  addr_t target;

  // Next fetch address
  always_comb begin
    target = targets_i.boot_addr;
    case (ctrl_i.pc_mux)
      PC_BOOT:     target = targets_i.boot_addr;
      PC_JUMP:     target = targets_i.jump_target;
      PC_BRANCH:   target = targets_i.branch_target;
      // Return from trap
      PC_MRET:     target = targets_i.mepc;
      // Return from debug mode
      PC_DRET:     target = targets_i.dpc;
      // Exceptions share the mtvec base
      PC_TRAP_EXC: target = {targets_i.mtvec_base, 7'b0};
      // Vectored interrupts, one word per index
      PC_TRAP_IRQ: target = {targets_i.mtvec_base, ctrl_i.mtvec_index, 2'b00};
      PC_TRAP_DBD: target = targets_i.dm_halt_addr;
      PC_TRAP_DBE: target = targets_i.dm_exception_addr;
      // NMI sits in a fixed vector slot
      PC_TRAP_NMI: target = {targets_i.mtvec_base, NMI_MTVEC_INDEX, 2'b00};
      default:     target = targets_i.boot_addr;
    endcase
  end

  // No 16-bit instructions, so low bits are dropped
  assign redirect_addr_o = {target[31:2], 2'b00};

  // CSR block loads mtvec on the boot jump
  assign csr_mtvec_init_o = ctrl_i.pc_set && (ctrl_i.pc_mux == PC_BOOT);

endmodule

`default_nettype wire

/* if_pkg.sv */
// Widths, types and constants shared by every fetch stage block
// Instructions are 32 bits and word aligned, there is no compressed support
// FETCH_DEPTH must stay a power of two, pointers wrap by overflow
`default_nettype none

package if_pkg;

  //////////////////////////////
  // Vector types
  //////////////////////////////

  typedef logic [31:0] addr_t;
  typedef logic [31:0] instr_word_t;
  // Upper bits of mtvec, the low 7 bits of the base are implied zero
  typedef logic [24:0] mtvec_base_t;
  typedef logic [4:0]  mtvec_index_t;
  typedef logic [7:0]  lfsr_t;
  typedef logic [3:0]  dummy_freq_t;
  typedef logic [5:0]  gap_cnt_t;

  // Fetch target sources driven by the controller
  typedef enum logic [3:0] {
    PC_BOOT     = 4'd0,
    PC_JUMP     = 4'd1,
    PC_BRANCH   = 4'd2,
    PC_MRET     = 4'd3,
    PC_DRET     = 4'd4,
    PC_TRAP_EXC = 4'd5,
    PC_TRAP_IRQ = 4'd6,
    PC_TRAP_DBD = 4'd7,
    PC_TRAP_DBE = 4'd8,
    PC_TRAP_NMI = 4'd9
  } pc_mux_e;

  //////////////////////////////
  // Bundles
  //////////////////////////////

  // Controller commands to IF
  typedef struct packed {
    logic         pc_set;
    pc_mux_e      pc_mux;
    mtvec_index_t mtvec_index;
    logic         kill_if;
    logic         halt_if;
  } ctrl_if_t;

  // Candidate redirect targets
  typedef struct packed {
    addr_t       boot_addr;
    addr_t       jump_target;
    addr_t       branch_target;
    addr_t       mepc;
    addr_t       dpc;
    addr_t       dm_halt_addr;
    addr_t       dm_exception_addr;
    mtvec_base_t mtvec_base;
  } pc_targets_t;

  // One fetched word with the address it came from
  typedef struct packed {
    addr_t       addr;
    instr_word_t word;
    logic        bus_err;
  } fetch_entry_t;

  typedef struct packed {
    logic        instr_valid;
    addr_t       pc;
    instr_word_t instr;
    logic        bus_err;
    logic        dummy;
  } if_id_pipe_t;

  typedef struct packed {
    logic        dummy_en;
    dummy_freq_t dummy_freq;
  } xsecure_ctrl_t;

  //////////////////////////////
  // Constants
  //////////////////////////////

  localparam mtvec_index_t NMI_MTVEC_INDEX = 5'd15;
  // Buffer depth, also the cap on requests in flight
  localparam int unsigned  FETCH_DEPTH     = 2;
  localparam int unsigned  FETCH_PTR_W     = $clog2(FETCH_DEPTH);
  // R-type ALU opcode, dummies always target x0
  localparam logic [6:0]   DUMMY_OPCODE    = 7'b0110011;
  localparam lfsr_t        LFSR_SEED       = 8'hA5;
  // x^8 + x^6 + x^5 + x^4 + 1
  localparam lfsr_t        LFSR_TAPS       = 8'hB8;

endpackage

`default_nettype wire

/* if_prefetch_ctrl.sv */
// Idle after reset until the first pc_set, then fetches consecutive words
// A request not yet granted is held stable even across a redirect
// Requests in flight plus buffered words never exceed FETCH_DEPTH
`timescale 1ns/10ps
`default_nettype none

module if_prefetch_ctrl import if_pkg::*; (
  input  logic         clk,
  input  logic         rst_n,
  input  logic         pc_set_i,
  input  addr_t        redirect_addr_i,
  input  logic [1:0]   fifo_free_i,
  output logic         instr_req_o,
  output addr_t        instr_addr_o,
  input  logic         instr_gnt_i,
  input  logic         instr_rvalid_i,
  input  instr_word_t  instr_rdata_i,
  input  logic         instr_err_i,
  output logic         push_o,
  output fetch_entry_t push_entry_o,
  output logic         flush_o,
  output logic         busy_o
);

  logic                   active_q;
  addr_t                  fetch_addr_q;
  logic                   hold_q;
  logic                   hold_stale_q;
  addr_t                  hold_addr_q;
  logic [1:0]             out_cnt_q;
  logic [1:0]             out_cnt_d;
  logic [1:0]             drop_cnt_q;
  addr_t                  addr_queue [FETCH_DEPTH];
  logic [FETCH_PTR_W-1:0] aq_wr_ptr_q;
  logic [FETCH_PTR_W-1:0] aq_rd_ptr_q;
  logic                   req_stale;
  logic                   accept;
  logic                   resp_drop;

  //////////////////////////////
  // Request side
  //////////////////////////////

  // Held request belongs to the old stream once a redirect was seen
  assign req_stale = hold_q && (hold_stale_q || pc_set_i);

  // New requests wait one cycle after a redirect
  assign instr_req_o  = hold_q || (active_q && !pc_set_i && (out_cnt_q < fifo_free_i));
  assign instr_addr_o = hold_q ? hold_addr_q : fetch_addr_q;
  assign accept       = instr_req_o && instr_gnt_i;

  //////////////////////////////
  // Response side
  //////////////////////////////

  // Oldest responses are the ones to throw away
  assign resp_drop = instr_rvalid_i && (drop_cnt_q != 2'd0);
  assign out_cnt_d = out_cnt_q + {1'b0, accept} - {1'b0, instr_rvalid_i};

  assign flush_o      = pc_set_i;
  assign push_o       = instr_rvalid_i && !resp_drop && !pc_set_i;
  assign push_entry_o = '{addr: addr_queue[aq_rd_ptr_q], word: instr_rdata_i,
                          bus_err: instr_err_i};
  assign busy_o       = hold_q || (out_cnt_q != 2'd0);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      active_q     <= 1'b0;
      fetch_addr_q <= '0;
      hold_q       <= 1'b0;
      hold_stale_q <= 1'b0;
      out_cnt_q    <= 2'd0;
      drop_cnt_q   <= 2'd0;
      aq_wr_ptr_q  <= '0;
      aq_rd_ptr_q  <= '0;
    end else begin
      hold_q       <= instr_req_o && !instr_gnt_i;
      hold_stale_q <= instr_req_o && !instr_gnt_i && req_stale;
      out_cnt_q    <= out_cnt_d;
      if (pc_set_i) begin
        active_q     <= 1'b1;
        fetch_addr_q <= redirect_addr_i;
        // Everything still in flight is from the old stream
        drop_cnt_q   <= out_cnt_d;
      end else begin
        if (accept && !req_stale) begin
          fetch_addr_q <= fetch_addr_q + 32'd4;
        end
        drop_cnt_q <= drop_cnt_q - {1'b0, resp_drop} + {1'b0, accept && req_stale};
      end
      if (accept) begin
        aq_wr_ptr_q <= aq_wr_ptr_q + FETCH_PTR_W'(1);
      end
      if (instr_rvalid_i) begin
        aq_rd_ptr_q <= aq_rd_ptr_q + FETCH_PTR_W'(1);
      end
    end
  end

  // Address of each request in flight, in bus order
  always_ff @(posedge clk) begin
    if (accept) begin
      addr_queue[aq_wr_ptr_q] <= instr_addr_o;
    end
    if (instr_req_o && !instr_gnt_i) begin
      hold_addr_q <= instr_addr_o;
    end
  end

endmodule

`default_nettype wire

/* if_stage_top.sv */
// Instruction fetch stage, nothing fetched until the first pc_set
// Bus is req/gnt/rvalid with in-order responses, one per grant
// Up to FETCH_DEPTH requests in flight
`timescale 1ns/10ps
`default_nettype none

module if_stage_top import if_pkg::*; (
  input  logic          clk,
  input  logic          rst_n,
  input  ctrl_if_t      ctrl_i,
  input  pc_targets_t   targets_i,
  input  xsecure_ctrl_t xsecure_i,
  input  logic          id_ready_i,
  // Instruction bus
  output logic          instr_req_o,
  output addr_t         instr_addr_o,
  input  logic          instr_gnt_i,
  input  logic          instr_rvalid_i,
  input  instr_word_t   instr_rdata_i,
  input  logic          instr_err_i,
  // To ID and CSR
  output if_id_pipe_t   if_id_pipe_o,
  output logic          if_valid_o,
  output logic          if_busy_o,
  output logic          csr_mtvec_init_o,
  output logic          lfsr_shift_o
);

  addr_t        redirect_addr;
  logic [1:0]   fifo_free;
  logic         push;
  fetch_entry_t push_entry;
  logic         flush;
  logic         head_valid;
  fetch_entry_t head;
  logic         pop;
  logic         issue;
  fetch_entry_t issue_entry;
  logic         issue_dummy;

  // Target select
  if_pc_mux i_if_pc_mux (
    .ctrl_i           (ctrl_i),
    .targets_i        (targets_i),
    .redirect_addr_o  (redirect_addr),
    .csr_mtvec_init_o (csr_mtvec_init_o)
  );

  // Bus requests
  if_prefetch_ctrl i_if_prefetch_ctrl (
    .clk             (clk),
    .rst_n           (rst_n),
    .pc_set_i        (ctrl_i.pc_set),
    .redirect_addr_i (redirect_addr),
    .fifo_free_i     (fifo_free),
    .instr_req_o     (instr_req_o),
    .instr_addr_o    (instr_addr_o),
    .instr_gnt_i     (instr_gnt_i),
    .instr_rvalid_i  (instr_rvalid_i),
    .instr_rdata_i   (instr_rdata_i),
    .instr_err_i     (instr_err_i),
    .push_o          (push),
    .push_entry_o    (push_entry),
    .flush_o         (flush),
    .busy_o          (if_busy_o)
  );

  // Response buffer
  if_fetch_fifo i_if_fetch_fifo (
    .clk          (clk),
    .rst_n        (rst_n),
    .flush_i      (flush),
    .push_i       (push),
    .push_entry_i (push_entry),
    .pop_i        (pop),
    .head_valid_o (head_valid),
    .head_o       (head),
    .free_o       (fifo_free)
  );

  // Issue with dummy insertion
  if_dummy_issue i_if_dummy_issue (
    .clk           (clk),
    .rst_n         (rst_n),
    .ctrl_i        (ctrl_i),
    .xsecure_i     (xsecure_i),
    .head_valid_i  (head_valid),
    .head_i        (head),
    .id_ready_i    (id_ready_i),
    .pop_o         (pop),
    .if_valid_o    (if_valid_o),
    .issue_o       (issue),
    .issue_entry_o (issue_entry),
    .issue_dummy_o (issue_dummy),
    .lfsr_shift_o  (lfsr_shift_o)
  );

  // IF/ID register
  if_id_register i_if_id_register (
    .clk           (clk),
    .rst_n         (rst_n),
    .issue_i       (issue),
    .issue_entry_i (issue_entry),
    .issue_dummy_i (issue_dummy),
    .id_ready_i    (id_ready_i),
    .if_id_pipe_o  (if_id_pipe_o)
  );

endmodule

`default_nettype wire

/* tb.f */
if_pkg.sv
if_pc_mux.sv
if_prefetch_ctrl.sv
if_fetch_fifo.sv
if_dummy_issue.sv
if_id_register.sv
if_stage_top.sv
tb_instr_mem.sv
tb_if_stage.sv

/* tb_if_stage.sv */
// Fetch stage testbench with random bus timing and random ID back-pressure
// Six phases of PHASE_LEN real instructions, checked at the falling edge
// kill_if is only raised together with pc_set, as the controller does
`timescale 1ns/10ps
`default_nettype none

module tb_if_stage import if_pkg::*; ();

  localparam int unsigned PHASE_LEN      = 400;
  // About 8 cycles per instruction in the worst case
  localparam int unsigned TIMEOUT_CYCLES = 6 * PHASE_LEN * 8 + 800;
  localparam addr_t       BOOT_ADDR      = 32'h0000_0180;
  localparam addr_t       ERR_BASE       = 32'h0000_0240;
  localparam instr_word_t WORD_KEY       = 32'h5A5A_0000;

  logic          clk = 1'b0;
  logic          rst_n;
  ctrl_if_t      ctrl;
  pc_targets_t   targets;
  xsecure_ctrl_t xsecure;
  logic          id_ready;
  logic          instr_req;
  addr_t         instr_addr;
  logic          instr_gnt;
  logic          instr_rvalid;
  instr_word_t   instr_rdata;
  logic          instr_err;
  if_id_pipe_t   if_id_pipe;
  logic          if_valid;
  logic          if_busy;
  logic          mtvec_init;
  logic          lfsr_shift;

  // Reference model and previous-cycle state
  int unsigned   errors = 0;
  int unsigned   real_cnt = 0;
  int unsigned   dummy_cnt = 0;
  int unsigned   err_hits = 0;
  int unsigned   cycles = 0;
  int unsigned   real_gap = 0;
  // Granted requests still waiting for their response
  int            in_flight = 0;
  addr_t         exp_pc = '0;
  logic          booted = 1'b0;
  logic          gap_known = 1'b0;
  logic          issued_last = 1'b0;
  logic          shift_last = 1'b0;
  logic          en_last = 1'b0;
  logic          stall_last = 1'b0;
  logic          hold_last = 1'b0;
  addr_t         addr_last = '0;
  if_id_pipe_t   pipe_last = '0;
  xsecure_ctrl_t xsec_last = '0;

  always #4 clk = ~clk;

  if_stage_top i_if_stage_top (
    .clk (clk), .rst_n (rst_n), .ctrl_i (ctrl), .targets_i (targets),
    .xsecure_i (xsecure), .id_ready_i (id_ready),
    .instr_req_o (instr_req), .instr_addr_o (instr_addr), .instr_gnt_i (instr_gnt),
    .instr_rvalid_i (instr_rvalid), .instr_rdata_i (instr_rdata), .instr_err_i (instr_err),
    .if_id_pipe_o (if_id_pipe), .if_valid_o (if_valid), .if_busy_o (if_busy),
    .csr_mtvec_init_o (mtvec_init), .lfsr_shift_o (lfsr_shift)
  );

  tb_instr_mem i_instr_mem (
    .clk (clk), .rst_n (rst_n), .req_i (instr_req), .addr_i (instr_addr),
    .err_base_i (ERR_BASE), .gnt_o (instr_gnt), .rvalid_o (instr_rvalid),
    .rdata_o (instr_rdata), .err_o (instr_err)
  );

  //////////////////////////////
  // Reporting and target rule
  //////////////////////////////

  task automatic report_mismatch(input string name, input logic [66:0] exp_v,
                                 input logic [66:0] got_v);
    errors++;
    $display("MISMATCH %s: expected %0h, got %0h at %0t", name, exp_v, got_v, $time);
  endtask

  task automatic report_failure(input string what);
    errors++;
    $display("ERROR at %0t: %s", $time, what);
  endtask

  // Word aligned target for a redirect
  function automatic addr_t expected_target(input ctrl_if_t c, input pc_targets_t t);
    addr_t a;
    case (c.pc_mux)
      PC_JUMP:     a = t.jump_target;
      PC_BRANCH:   a = t.branch_target;
      PC_MRET:     a = t.mepc;
      PC_DRET:     a = t.dpc;
      PC_TRAP_EXC: a = {t.mtvec_base, 7'd0};
      PC_TRAP_IRQ: a = {t.mtvec_base, c.mtvec_index, 2'd0};
      PC_TRAP_DBD: a = t.dm_halt_addr;
      PC_TRAP_DBE: a = t.dm_exception_addr;
      PC_TRAP_NMI: a = {t.mtvec_base, NMI_MTVEC_INDEX, 2'd0};
      default:     a = t.boot_addr;
    endcase
    return {a[31:2], 2'b00};
  endfunction

  function automatic logic in_err_window(input addr_t a);
    return (a >= ERR_BASE) && (a < ERR_BASE + 32'd16);
  endfunction

  //////////////////////////////
  // Checks
  //////////////////////////////

  // Entry that was issued in the previous cycle
  task automatic check_entry();
    if_id_pipe_t p;
    int unsigned gap_max;
    p       = if_id_pipe;
    // Gap bound of the settings in force when the entry was issued
    gap_max = 4 * (int'(xsec_last.dummy_freq) + 1);
    assert (p.instr_valid) else report_failure("issued instruction not valid in ID");
    assert (p.dummy == shift_last)
      else report_mismatch("if_id_pipe_o.dummy", shift_last, p.dummy);
    if (p.dummy) begin
      dummy_cnt++;
      assert (en_last) else report_failure("dummy instruction while dummy_en is clear");
      assert (p.instr[11:0] == {5'd0, DUMMY_OPCODE})
        else report_mismatch("if_id_pipe_o.instr[11:0]", {5'd0, DUMMY_OPCODE}, p.instr[11:0]);
      assert (!p.bus_err) else report_mismatch("if_id_pipe_o.bus_err", 1'b0, p.bus_err);
      if (gap_known) begin
        assert (real_gap >= 1 && real_gap <= gap_max)
          else report_failure($sformatf("%0d real instructions between dummies", real_gap));
      end
      gap_known = 1'b1;
      real_gap  = 0;
    end else begin
      real_cnt++;
      real_gap++;
      assert (p.pc == exp_pc) else report_mismatch("if_id_pipe_o.pc", exp_pc, p.pc);
      assert (p.instr == (exp_pc ^ WORD_KEY))
        else report_mismatch("if_id_pipe_o.instr", exp_pc ^ WORD_KEY, p.instr);
      assert (p.bus_err == in_err_window(exp_pc))
        else report_mismatch("if_id_pipe_o.bus_err", in_err_window(exp_pc), p.bus_err);
      if (p.bus_err) begin
        err_hits++;
      end
      exp_pc = exp_pc + 32'd4;
    end
  endtask

  // Mid-cycle, inputs and DUT outputs are settled here
  always @(negedge clk) begin
    if (rst_n) begin
      if (!booted) begin
        assert (!instr_req && !if_valid && !lfsr_shift && !if_id_pipe.instr_valid)
          else report_failure("DUT active before the first pc_set");
      end
      assert (mtvec_init == (ctrl.pc_set && ctrl.pc_mux == PC_BOOT))
        else report_mismatch("csr_mtvec_init_o", ctrl.pc_set && ctrl.pc_mux == PC_BOOT,
                             mtvec_init);
      if (ctrl.halt_if || ctrl.kill_if) begin
        assert (!if_valid) else report_failure("if_valid_o high during halt or kill");
      end
      if (lfsr_shift) begin
        assert (if_valid && id_ready) else report_failure("lfsr_shift_o without an issue");
      end
      // Bus request waiting for its grant
      if (stall_last) begin
        assert (instr_req) else report_failure("instr_req_o dropped before its grant");
        assert (instr_addr == addr_last)
          else report_mismatch("instr_addr_o", addr_last, instr_addr);
      end
      // Busy follows the bus traffic
      if (in_flight != 0) begin
        assert (if_busy) else report_failure("if_busy_o low with responses outstanding");
      end
      if (if_busy) begin
        assert (in_flight != 0 || instr_req)
          else report_failure("if_busy_o high with an idle bus");
      end
      if (hold_last) begin
        assert (if_id_pipe == pipe_last)
          else report_mismatch("if_id_pipe_o", pipe_last, if_id_pipe);
      end
      if (issued_last) begin
        check_entry();
      end else if (!hold_last) begin
        // ID took the old entry and nothing new came in
        assert (!if_id_pipe.instr_valid)
          else report_failure("instr_valid high in ID without a new issue");
      end
      if (ctrl.pc_set) begin
        exp_pc = expected_target(ctrl, targets);
        booted = 1'b1;
      end
      // New dummy settings, the next interval is not bounded yet
      if (xsecure != xsec_last) begin
        gap_known = 1'b0;
      end
      issued_last = if_valid && id_ready;
      shift_last  = lfsr_shift;
      en_last     = xsecure.dummy_en;
      stall_last  = instr_req && !instr_gnt;
      addr_last   = instr_addr;
      hold_last   = !id_ready;
      pipe_last   = if_id_pipe;
      xsec_last   = xsecure;
      in_flight   = in_flight + int'(instr_req && instr_gnt) - int'(instr_rvalid);
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, %0d real instructions", cycles, real_cnt);
      $display("Test failed");
      $finish;
    end
  end

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  // Random targets, then a one-cycle redirect with kill
  task automatic load_redirect(input pc_mux_e sel);
    targets.boot_addr         = $urandom & 32'h0000_0FFF;
    targets.jump_target       = $urandom & 32'h0000_0FFF;
    targets.branch_target     = $urandom & 32'h0000_0FFF;
    targets.mepc              = $urandom & 32'h0000_0FFF;
    targets.dpc               = $urandom & 32'h0000_0FFF;
    targets.dm_halt_addr      = $urandom & 32'h0000_0FFF;
    targets.dm_exception_addr = $urandom & 32'h0000_0FFF;
    targets.mtvec_base        = 25'($urandom % 32);
    ctrl.mtvec_index          = 5'($urandom);
    ctrl.pc_mux               = sel;
    ctrl.pc_set               = 1'b1;
    ctrl.kill_if              = 1'b1;
  endtask

  task automatic run_phase(input int unsigned n_real, input int unsigned redirect_pct,
                           input int unsigned halt_pct);
    int unsigned goal;
    goal = real_cnt + n_real;
    while (real_cnt < goal) begin
      @(posedge clk);
      #1;
      ctrl.pc_set  = 1'b0;
      ctrl.kill_if = 1'b0;
      id_ready     = ($urandom % 4) != 0;
      ctrl.halt_if = ($urandom % 100) < halt_pct;
      if (($urandom % 100) < redirect_pct) begin
        load_redirect(pc_mux_e'(4'($urandom % 10)));
      end
    end
  endtask

  initial begin
    void'($urandom(69402));
    rst_n    = 1'b0;
    ctrl     = '0;
    targets  = '0;
    xsecure  = '0;
    id_ready = 1'b0;
    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(posedge clk);
    #1;
    // Boot and plain sequential fetch across the error window
    load_redirect(PC_BOOT);
    targets.boot_addr = BOOT_ADDR;
    run_phase(PHASE_LEN, 0, 0);
    // Every redirect source, four rounds
    for (int r = 0; r < 4; r++) begin
      for (int m = 0; m < 10; m++) begin
        @(posedge clk);
        #1;
        load_redirect(pc_mux_e'(4'(m)));
        run_phase(PHASE_LEN / 40, 0, 0);
      end
    end
    run_phase(PHASE_LEN, 0, 25);
    // Dummy insertion, shortest and longest gaps
    xsecure = '{dummy_en: 1'b1, dummy_freq: 4'd0};
    run_phase(PHASE_LEN, 0, 10);
    xsecure = '{dummy_en: 1'b1, dummy_freq: 4'd15};
    run_phase(PHASE_LEN, 2, 10);
    xsecure = '0;
    run_phase(PHASE_LEN, 2, 10);
    @(posedge clk);
    #1;
    ctrl.halt_if = 1'b0;
    repeat (4) @(posedge clk);
    if (dummy_cnt == 0) begin
      report_failure("no dummy instruction reached ID");
    end
    if (err_hits == 0) begin
      report_failure("no bus error reached ID");
    end
    $display("Errors: %0d, real instructions: %0d, dummies: %0d, bus errors: %0d",
             errors, real_cnt, dummy_cnt, err_hits);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tb_instr_mem.sv */
// Behavioral instruction memory, every word is its address XOR 32'h5A5A0000
// Grant gaps and response delays are random, 0 to 3 cycles, responses stay in order
// instr_err is returned for the 16-byte window that starts at err_base_i
`timescale 1ns/10ps
`default_nettype none

module tb_instr_mem import if_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        req_i,
  input  addr_t       addr_i,
  input  addr_t       err_base_i,
  output logic        gnt_o,
  output logic        rvalid_o,
  output instr_word_t rdata_o,
  output logic        err_o
);

  addr_t       pend_addr [$];
  int unsigned pend_due [$];
  int unsigned cycle = 0;
  int unsigned gnt_wait = 0;
  int unsigned due;
  addr_t       raddr;
  logic        gnt_nxt = 1'b0;
  logic        rvalid_nxt = 1'b0;
  addr_t       raddr_nxt = '0;
  logic        err_nxt = 1'b0;

  initial begin
    gnt_o    = 1'b0;
    rvalid_o = 1'b0;
    rdata_o  = '0;
    err_o    = 1'b0;
  end

  // Bookkeeping mid-cycle, where the bus signals are settled
  always @(negedge clk) begin
    if (!rst_n) begin
      pend_addr.delete();
      pend_due.delete();
      cycle      = 0;
      gnt_wait   = 0;
      gnt_nxt    = 1'b0;
      rvalid_nxt = 1'b0;
    end else begin
      cycle++;
      // Accepted request, queue it with its earliest response cycle
      if (req_i && gnt_o) begin
        due = cycle + 1 + ($urandom % 4);
        pend_addr.push_back(addr_i);
        pend_due.push_back(due);
        gnt_wait = $urandom % 4;
      end else if (gnt_wait != 0) begin
        gnt_wait--;
      end
      gnt_nxt = (gnt_wait == 0);
      // One response per cycle, oldest first
      rvalid_nxt = 1'b0;
      if (pend_due.size() != 0 && pend_due[0] <= cycle + 1) begin
        raddr = pend_addr.pop_front();
        void'(pend_due.pop_front());
        rvalid_nxt = 1'b1;
        raddr_nxt  = raddr;
        err_nxt    = (raddr >= err_base_i) && (raddr < err_base_i + 32'd16);
      end
    end
  end

  // Outputs change just after the rising edge
  always @(posedge clk) begin
    #1;
    gnt_o    = gnt_nxt;
    rvalid_o = rvalid_nxt;
    rdata_o  = raddr_nxt ^ 32'h5A5A_0000;
    err_o    = rvalid_nxt && err_nxt;
  end

endmodule

`default_nettype wire
